// ==== run.sh ====
#!/usr/bin/env bash
# Builds the ALU slice testbench with Verilator and runs it from the project root
set -u
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -f src.f --top-module alu_tb -o alu_tb_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/alu_tb_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit $status
fi
exit 0

// ==== src.f ====
+incdir+src
src/alu_pkg.sv
src/alu_ctrl.sv
src/alu_core.sv
src/alu_shift.sv
src/alu_sts.sv
src/alu_outmux.sv
src/alu_top.sv
verification/alu_chk.sv
verification/alu_tb.sv

// ==== src/alu_core.sv ====
// ALU function unit: R/S operand selection, eight functions and live flags, all combinational
`timescale 1ns/10ps
`include "alu_defs.svh"

module alu_core import alu_pkg::*; (
  input  logic [`ALU_W-1:0] a,
  input  logic [`ALU_W-1:0] b,
  input  logic [`ALU_W-1:0] d,     // Direct operand
  input  logic [`ALU_W-1:0] q,
  input  src_e              src,
  input  fn_e               fn,
  input  logic              cin,
  output logic [`ALU_W-1:0] f,
  output logic              cry,
  output logic              ovf,
  output logic              zf,
  output logic              mi
);

  logic [`ALU_W-1:0] r;
  logic [`ALU_W-1:0] s;
  logic [`ALU_W-1:0] x;     // Adder operands after complement
  logic [`ALU_W-1:0] y;
  logic [`ALU_W:0]   sum;   // Carry in MSB
  logic              arith;

  // Source pairs
  always_comb begin
    unique case (src)
      SRC_AQ:  begin r = a;  s = q;  end
      SRC_AB:  begin r = a;  s = b;  end
      SRC_ZQ:  begin r = '0; s = q;  end
      SRC_ZB:  begin r = '0; s = b;  end
      SRC_ZA:  begin r = '0; s = a;  end
      SRC_DA:  begin r = d;  s = a;  end
      SRC_DQ:  begin r = d;  s = q;  end
      default: begin r = d;  s = '0; end   // DZ
    endcase
  end

  // Subtract as one's complement plus carry-in
  always_comb begin
    x = r;
    y = s;
    if (fn == FN_SUBR) begin
      x = s;
      y = ~r;
    end else if (fn == FN_SUBS) begin
      y = ~s;
    end
  end

  assign sum   = {1'b0, x} + {1'b0, y} + {{`ALU_W{1'b0}}, cin};
  assign arith = (fn == FN_ADD) | (fn == FN_SUBR) | (fn == FN_SUBS);

  always_comb begin
    unique case (fn)
      FN_OR:    f = r | s;
      FN_AND:   f = r & s;
      FN_NOTRS: f = ~r & s;
      FN_EXOR:  f = r ^ s;
      FN_EXNOR: f = ~(r ^ s);
      default:  f = sum[`ALU_W-1:0];   // Arithmetic
    endcase
  end

  assign cry = arith & sum[`ALU_W];
  // Same-sign addends giving a different-sign result
  assign ovf = arith & (x[`ALU_W-1] == y[`ALU_W-1]) & (sum[`ALU_W-1] != x[`ALU_W-1]);
  assign zf  = (f == '0);
  assign mi  = f[`ALU_W-1];

endmodule

// ==== src/alu_ctrl.sv ====
// Micro-op decode for the ALU slice; drives operand, function, carry-in, shift and Q controls
`timescale 1ns/10ps
`include "alu_defs.svh"

module alu_ctrl import alu_pkg::*; (
  input  logic [`ALUI_W-1:0] alu_i,     // Micro-op ALU field
  input  cin_e               cin_sel,
  input  shl_e               shl_sel,
  input  logic               c_stored,  // C from status word
  input  logic               f_lsb,
  input  logic               f_msb,
  input  logic               q_lsb,
  input  logic               q_msb,
  output src_e               src,
  output fn_e                fn,
  output logic               cin,
  output logic [`SH_W-1:0]   f_dir,
  output logic               q_load,
  output logic [`SH_W-1:0]   q_dir,
  output logic               f_link,
  output logic               q_link
);

  dst_e dst;
  logic link_fix;   // Link from fixed/stored choice
  logic rot;        // Rotate selected

  // Field groups, 2901 order
  assign src = src_e'(alu_i[2:0]);
  assign fn  = fn_e'(alu_i[5:3]);
  assign dst = dst_e'(alu_i[8:6]);

  always_comb begin
    unique case (cin_sel)
      CIN_ZERO:    cin = 1'b0;
      CIN_ONE:     cin = 1'b1;
      CIN_CSTORED: cin = c_stored;
      default:     cin = ~c_stored;   // Inverted carry for borrow chains
    endcase
  end

  assign rot = (shl_sel == SHL_ROT);
  assign link_fix = (shl_sel == SHL_ONE) | ((shl_sel == SHL_CSTORED) & c_stored);

  // Shift policy per destination
  always_comb begin
    f_dir  = `SH_NONE;
    q_dir  = `SH_NONE;
    q_load = 1'b0;
    f_link = 1'b0;
    q_link = 1'b0;
    unique case (dst)
      DST_QREG: q_load = 1'b1;           // Q <= F
      DST_RAMQD: begin
        f_dir  = `SH_RIGHT;
        q_dir  = `SH_RIGHT;
        q_load = 1'b1;
        f_link = rot ? q_lsb : link_fix; // Rotate 32 bits F:Q
        q_link = f_lsb;                  // F0 falls into Q15
      end
      DST_RAMD: begin
        f_dir  = `SH_RIGHT;
        f_link = rot ? f_lsb : link_fix;
      end
      DST_RAMQU: begin
        f_dir  = `SH_LEFT;
        q_dir  = `SH_LEFT;
        q_load = 1'b1;
        f_link = q_msb;                  // Q15 climbs into F0
        q_link = rot ? f_msb : link_fix;
      end
      DST_RAMU: begin
        f_dir  = `SH_LEFT;
        f_link = rot ? f_msb : link_fix;
      end
      default: ;                         // NOP, RAMA, RAMF pass F
    endcase
  end

endmodule

// ==== src/alu_defs.svh ====
// Shared widths and shift-direction codes for the ALU slice, included by RTL and testbench
`ifndef ALU_DEFS_SVH
`define ALU_DEFS_SVH

`define ALU_W  16       // Datapath word
`define ALUI_W 9        // Source, function, destination groups of 3
`define IDBS_W 3        // Bus source select
`define PIL_W  4        // Priority interrupt level

// Shift direction codes, ctrl to shifter
`define SH_W     2
`define SH_NONE  2'd0   // Pass through, or load F into Q
`define SH_RIGHT 2'd1   // Down shift
`define SH_LEFT  2'd2   // Up shift

`endif

// ==== src/alu_outmux.sv ====
// Internal data bus driver: picks one of eight sources and registers it onto fidbo
`timescale 1ns/10ps
`include "alu_defs.svh"

module alu_outmux import alu_pkg::*; (
  input  logic              sysclk,
  input  logic              arst_n,
  input  idbs_e             idbs,
  input  logic [`ALU_W-1:0] f,
  input  logic [`ALU_W-1:0] a,
  input  sts_u              sts,
  input  logic [`ALU_W-1:0] q,
  input  logic [`ALU_W-1:0] cd,
  input  logic [`ALU_W-1:0] csbit,   // Microcode argument
  input  logic [`ALU_W-1:0] rb,
  output logic [`ALU_W-1:0] fidbo
);

  logic [`ALU_W-1:0] sw;     // F with bytes exchanged
  logic [`ALU_W-1:0] sel;

  assign sw = {f[7:0], f[`ALU_W-1:8]};

  always_comb begin
    unique case (idbs)
      IDBS_F:    sel = f;
      IDBS_A:    sel = a;
      IDBS_STS:  sel = sts.word;   // Raw status read
      IDBS_Q:    sel = q;
      IDBS_SWAP: sel = sw;
      IDBS_CD:   sel = cd;
      IDBS_ARG:  sel = csbit;
      default:   sel = rb;         // Shifter output
    endcase
  end

  // Bus value appears one edge after the micro-op
  always_ff @(posedge sysclk or negedge arst_n) begin
    if (!arst_n) begin
      fidbo <= '0;
    end else begin
      fidbo <= sel;
    end
  end

endmodule

// ==== src/alu_pkg.sv ====
// Types for the ALU slice, imported by modules that decode micro-op fields or the status word
`include "alu_defs.svh"

package alu_pkg;

  // Status word, field view, MSB first
  typedef struct packed {
    logic               ion;       // Interrupt system on
    logic               pon;       // Paging on
    logic               dbl;       // Double word mode
    logic               spare12;
    logic [`PIL_W-1:0]  pil;       // Current level
    logic               m;         // Sign of last result
    logic               o;         // Overflow
    logic               c;         // Carry
    logic               spare4;
    logic               z;         // Zero
    logic [1:0]         spare2_1;
    logic               ptm;       // Page table mode
  } sts_f_t;

  // Raw word for bus and whole-word load, fields for flag and PIL updates
  typedef union packed {
    logic [`ALU_W-1:0] word;
    sts_f_t            f;
  } sts_u;

  // 2901 source operand pairs, R then S
  typedef enum logic [2:0] {
    SRC_AQ, SRC_AB, SRC_ZQ, SRC_ZB, SRC_ZA, SRC_DA, SRC_DQ, SRC_DZ
  } src_e;

  typedef enum logic [2:0] {
    FN_ADD, FN_SUBR, FN_SUBS, FN_OR, FN_AND, FN_NOTRS, FN_EXOR, FN_EXNOR
  } fn_e;

  typedef enum logic [2:0] {
    DST_QREG, DST_NOP, DST_RAMA, DST_RAMF, DST_RAMQD, DST_RAMD, DST_RAMQU, DST_RAMU
  } dst_e;

  typedef enum logic [1:0] {CIN_ZERO, CIN_ONE, CIN_CSTORED, CIN_CINV} cin_e;

  typedef enum logic [1:0] {SHL_ZERO, SHL_ONE, SHL_CSTORED, SHL_ROT} shl_e;

  typedef enum logic [1:0] {STS_HOLD, STS_FLAGS, STS_WORD, STS_PIL} sts_op_e;

  typedef enum logic [`IDBS_W-1:0] {
    IDBS_F, IDBS_A, IDBS_STS, IDBS_Q, IDBS_SWAP, IDBS_CD, IDBS_ARG, IDBS_RB
  } idbs_e;

endpackage

// ==== src/alu_shift.sv ====
// Destination shifter: shifted F onto RB plus the Q register, loaded or shifted per micro-op
`timescale 1ns/10ps
`include "alu_defs.svh"

module alu_shift (
  input  logic              sysclk,
  input  logic              arst_n,
  input  logic [`ALU_W-1:0] f,
  input  logic [`SH_W-1:0]  f_dir,
  input  logic              f_link,   // Bit entering F's open end
  input  logic              q_link,   // Bit entering Q's open end
  input  logic              q_load,
  input  logic [`SH_W-1:0]  q_dir,    // NONE here means load F
  output logic [`ALU_W-1:0] rb,
  output logic [`ALU_W-1:0] q
);

  logic [`ALU_W-1:0] q_nxt;

  // One-place shift, link fills the vacated end
  function automatic logic [`ALU_W-1:0] shift1(
    input logic [`ALU_W-1:0] val,
    input logic [`SH_W-1:0]  dir,
    input logic              link
  );
    logic [`ALU_W-1:0] res;
    res = val;
    if (dir == `SH_RIGHT) begin
      res = {link, val[`ALU_W-1:1]};
    end else if (dir == `SH_LEFT) begin
      res = {val[`ALU_W-2:0], link};
    end
    return res;
  endfunction

  assign rb = shift1(f, f_dir, f_link);

  // QREG takes F, QD/QU shift Q alongside F
  assign q_nxt = (q_dir == `SH_NONE) ? f : shift1(q, q_dir, q_link);

  always_ff @(posedge sysclk or negedge arst_n) begin
    if (!arst_n) begin
      q <= '0;
    end else if (q_load) begin
      q <= q_nxt;
    end
  end

endmodule

// ==== src/alu_sts.sv ====
// Status register: flag updates, whole-word load from CD and PIL load, read back as a word
`timescale 1ns/10ps
`include "alu_defs.svh"

module alu_sts import alu_pkg::*; (
  input  logic              sysclk,
  input  logic              arst_n,
  input  sts_op_e           sts_op,
  input  logic              cry,
  input  logic              ovf,
  input  logic              zf,
  input  logic              mi,
  input  logic [`ALU_W-1:0] cd,
  output sts_u              sts,
  output logic              c_stored,
  output logic [`PIL_W-1:0] pil
);

  sts_u sts_r;

  always_ff @(posedge sysclk or negedge arst_n) begin
    if (!arst_n) begin
      sts_r.word <= '0;
    end else begin
      unique case (sts_op)
        STS_FLAGS: begin        // Only c, o, z, m move
          sts_r.f.c <= cry;
          sts_r.f.o <= ovf;
          sts_r.f.z <= zf;
          sts_r.f.m <= mi;
        end
        STS_WORD: sts_r.word <= cd;
        STS_PIL:  sts_r.f.pil <= cd[11:8];   // Level field of CD
        default: ;                           // Hold
      endcase
    end
  end

  assign sts      = sts_r;
  assign c_stored = sts_r.f.c;   // For CSTORED carry and link
  assign pil      = sts_r.f.pil;

endmodule

// ==== src/alu_top.sv ====
// ALU slice top level: wires decode, function unit, shifter, status register and bus mux
`timescale 1ns/10ps
`include "alu_defs.svh"

module alu_top import alu_pkg::*; (
  input  logic               sysclk,
  input  logic               arst_n,
  input  logic [`ALU_W-1:0]  a,
  input  logic [`ALU_W-1:0]  b,
  input  logic [`ALU_W-1:0]  cd,
  input  logic [`ALU_W-1:0]  csbit,
  input  logic [`ALUI_W-1:0] alu_i,
  input  cin_e               cin_sel,
  input  shl_e               shl_sel,
  input  sts_op_e            sts_op,
  input  idbs_e              idbs,
  output logic [`ALU_W-1:0]  fidbo,
  output logic [`ALU_W-1:0]  rb,
  output logic [`ALU_W-1:0]  sts,
  output logic [`PIL_W-1:0]  pil,
  output logic               cry,
  output logic               ovf,
  output logic               zf,
  output logic               mi,
  output logic               f11,
  output logic               f15
);

  src_e              src;
  fn_e               fn;
  logic              cin;
  logic [`SH_W-1:0]  f_dir;
  logic [`SH_W-1:0]  q_dir;
  logic              q_load;
  logic              f_link;
  logic              q_link;
  logic              c_stored;
  logic [`ALU_W-1:0] f;
  logic [`ALU_W-1:0] q;
  sts_u              sts_w;

  assign sts = sts_w.word;
  assign f11 = f[11];
  assign f15 = f[`ALU_W-1];

  alu_ctrl alu_ctrl_i (
    .alu_i(alu_i), .cin_sel(cin_sel), .shl_sel(shl_sel), .c_stored(c_stored),
    .f_lsb(f[0]), .f_msb(f[`ALU_W-1]), .q_lsb(q[0]), .q_msb(q[`ALU_W-1]),
    .src(src), .fn(fn), .cin(cin), .f_dir(f_dir), .q_load(q_load),
    .q_dir(q_dir), .f_link(f_link), .q_link(q_link)
  );

  alu_core alu_core_i (
    .a(a), .b(b), .d(cd), .q(q), .src(src), .fn(fn), .cin(cin),   // D operand is CD
    .f(f), .cry(cry), .ovf(ovf), .zf(zf), .mi(mi)
  );

  alu_shift alu_shift_i (
    .sysclk(sysclk), .arst_n(arst_n), .f(f), .f_dir(f_dir), .f_link(f_link),
    .q_link(q_link), .q_load(q_load), .q_dir(q_dir), .rb(rb), .q(q)
  );

  alu_sts alu_sts_i (
    .sysclk(sysclk), .arst_n(arst_n), .sts_op(sts_op), .cry(cry), .ovf(ovf),
    .zf(zf), .mi(mi), .cd(cd), .sts(sts_w), .c_stored(c_stored), .pil(pil)
  );

  alu_outmux alu_outmux_i (
    .sysclk(sysclk), .arst_n(arst_n), .idbs(idbs), .f(f), .a(a), .sts(sts_w),
    .q(q), .cd(cd), .csbit(csbit), .rb(rb), .fidbo(fidbo)
  );

endmodule

// ==== verification/alu_chk.sv ====
// Checker bound into the ALU slice top level; watches bus reset, stored zero flag and PIL load
`timescale 1ns/10ps
`include "alu_defs.svh"

module alu_chk import alu_pkg::*; (
  input logic              sysclk,
  input logic              arst_n,
  input logic [`ALU_W-1:0] fidbo,
  input logic [`ALU_W-1:0] f,      // Live function unit result
  input logic [`ALU_W-1:0] sts,
  input logic [`PIL_W-1:0] pil,
  input logic [`ALU_W-1:0] cd,     // Level source for PIL loads
  input sts_op_e           sts_op
);

  // First edge out of reset still shows the cleared bus
  a_fidbo_after_reset: assert property (@(posedge sysclk) $rose(arst_n) |-> fidbo == '0)
    else $error("fidbo %h not zero on first edge after reset", fidbo);

  // Stored Z is the F zero test of the flag-update cycle
  a_z_stored: assert property (@(posedge sysclk) disable iff (!arst_n)
    sts_op == STS_FLAGS |=> sts[3] == $past(f == '0))
    else $error("status z %b wrong after flag update", sts[3]);

  // PIL load moves only the level, which shows on pil
  a_pil_load: assert property (@(posedge sysclk) disable iff (!arst_n)
    sts_op == STS_PIL |=> pil == $past(cd[11:8])
      && {sts[15:12], sts[7:0]} == $past({sts[15:12], sts[7:0]}))
    else $error("pil %h or status %h wrong after PIL load", pil, sts);

endmodule

// ==== verification/alu_tb.sv ====
// Testbench for the ALU slice; builds a stimulus table with a reference model, applies it per cycle
`timescale 1ns/10ps
`include "alu_defs.svh"

module alu_tb import alu_pkg::*; ();

  localparam int CLK_NS   = 4;
  localparam int MAX_ROWS = 512;

  typedef struct packed {
    logic [`ALU_W-1:0]  a, b, cd, csbit;
    logic [`ALUI_W-1:0] alu_i;                 // dst, fn, src
    logic [1:0]         cin_sel, shl_sel, sts_op;
    logic [2:0]         idbs;
    logic [`ALU_W-1:0]  exp_f, exp_rb;
    logic [`ALU_W-1:0]  exp_sts;               // Status while row is applied
    logic [`ALU_W-1:0]  exp_fidbo;             // Bus one edge later
    logic [3:0]         exp_flags;             // cry, ovf, zf, mi
  } row_t;

  logic sysclk, arst_n;
  logic [`ALU_W-1:0] a, b, cd, csbit, fidbo, rb, sts;
  logic [`ALUI_W-1:0] alu_i;
  cin_e cin_sel;
  shl_e shl_sel;
  sts_op_e sts_op;
  idbs_e idbs;
  logic [`PIL_W-1:0] pil;
  logic cry, ovf, zf, mi, f11, f15;

  row_t tbl [MAX_ROWS];
  int n_rows = 0;
  int seed = 99180;
  logic built = 1'b0;
  logic [`ALU_W-1:0] m_q = '0;     // Model Q
  logic [`ALU_W-1:0] m_sts = '0;   // Model status word

  alu_top alu_top_i (.*);

  bind alu_top alu_chk alu_chk_i (
    .sysclk(sysclk), .arst_n(arst_n), .fidbo(fidbo), .f(f), .sts(sts), .pil(pil),
    .cd(cd), .sts_op(sts_op)
  );

  function automatic logic [`ALU_W-1:0] rand_word();
    return 16'($random(seed));
  endfunction

  // Reference model, one micro-op; appends the row and advances Q and status
  task automatic add_row(input logic [`ALU_W-1:0] ra, rbin, rcd, rcs,
                         input logic [2:0] dst, fnc, src, input logic [1:0] cs, shl, so,
                         input logic [2:0] ids);
    logic [`ALU_W-1:0] r, s, x, y, f, rbv, qn, sn;
    logic [31:0] fq;                 // F above Q for double shifts
    logic ci, cy, ov, lk;
    int tot, st;
    row_t row;
    case (src)
      3'd0: {r, s} = {ra, m_q};
      3'd1: {r, s} = {ra, rbin};
      3'd2: {r, s} = {16'h0, m_q};
      3'd3: {r, s} = {16'h0, rbin};
      3'd4: {r, s} = {16'h0, ra};
      3'd5: {r, s} = {rcd, ra};
      3'd6: {r, s} = {rcd, m_q};
      default: {r, s} = {rcd, 16'h0};
    endcase
    ci = (cs == 2'd1) || (cs == 2'd2 && m_sts[5]) || (cs == 2'd3 && !m_sts[5]);
    x = (fnc == 3'd1) ? s : r;
    y = (fnc == 3'd1) ? ~r : (fnc == 3'd2) ? ~s : s;   // Subtrahend complemented
    tot = int'(x) + int'(y) + int'(ci);
    st = int'($signed(x)) + int'($signed(y)) + int'(ci);
    cy = 1'b0;
    ov = 1'b0;
    case (fnc)
      3'd3: f = r | s;
      3'd4: f = r & s;
      3'd5: f = ~r & s;
      3'd6: f = r ^ s;
      3'd7: f = ~(r ^ s);
      default: begin
        f = tot[15:0];
        cy = tot[16];
        ov = (st > 32767) || (st < -32768);   // Signed result out of range
      end
    endcase
    // Rotate link is the far end of F, or of F:Q for double shifts
    lk = (shl == 2'd3) ? ((dst == 3'd4) ? m_q[0] : (dst == 3'd5) ? f[0] : f[15])
                       : (shl == 2'd1) || (shl == 2'd2 && m_sts[5]);
    fq = {f, m_q};
    rbv = f;
    qn = m_q;
    case (dst)
      3'd0: qn = f;
      3'd4: {rbv, qn} = {lk, fq[31:1]};
      3'd5: rbv = {lk, f[15:1]};
      3'd6: {rbv, qn} = {fq[30:0], lk};
      3'd7: rbv = {f[14:0], lk};
      default: ;
    endcase
    sn = m_sts;
    case (so)
      2'd1: {sn[7], sn[6], sn[5], sn[3]} = {f[15], ov, cy, f == 16'h0};
      2'd2: sn = rcd;
      2'd3: sn[11:8] = rcd[11:8];
      default: ;
    endcase
    case (ids)
      3'd0: row.exp_fidbo = f;
      3'd1: row.exp_fidbo = ra;
      3'd2: row.exp_fidbo = m_sts;
      3'd3: row.exp_fidbo = m_q;
      3'd4: row.exp_fidbo = {f[7:0], f[15:8]};
      3'd5: row.exp_fidbo = rcd;
      3'd6: row.exp_fidbo = rcs;
      default: row.exp_fidbo = rbv;
    endcase
    {row.a, row.b, row.cd, row.csbit} = {ra, rbin, rcd, rcs};
    {row.alu_i, row.cin_sel, row.shl_sel, row.sts_op, row.idbs} = {dst, fnc, src, cs, shl, so, ids};
    {row.exp_f, row.exp_rb, row.exp_sts} = {f, rbv, m_sts};
    row.exp_flags = {cy, ov, f == 16'h0, f[15]};
    tbl[n_rows] = row;
    n_rows++;
    m_q = qn;
    m_sts = sn;
  endtask

  task automatic build_table();
    logic [`ALU_W-1:0] w;
    add_row('0, '0, '0, '0, DST_NOP, FN_OR, SRC_ZA, CIN_ZERO, SHL_ZERO, STS_HOLD, IDBS_Q);
    add_row('0, '0, '0, '0, DST_NOP, FN_OR, SRC_ZA, CIN_ZERO, SHL_ZERO, STS_HOLD, IDBS_STS);
    for (int k = 0; k < 256; k++) begin            // fn x src x carry-in
      w = rand_word();
      add_row(rand_word(), rand_word(), rand_word(), rand_word(), w[0] ? DST_QREG : DST_NOP,
              3'(k >> 5), 3'(k >> 2), 2'(k), SHL_ZERO, w[1] ? STS_FLAGS : STS_HOLD, w[4:2]);
    end
    add_row(16'h7FFF, 16'h0001, '0, '0, DST_NOP, FN_ADD, SRC_AB, CIN_ZERO, SHL_ZERO, STS_FLAGS,
            IDBS_STS);                              // Signed overflow
    add_row(16'hFFFF, 16'h0001, '0, '0, DST_NOP, FN_ADD, SRC_AB, CIN_ZERO, SHL_ZERO, STS_FLAGS,
            IDBS_F);                                // Carry out, zero result
    add_row(16'h1234, 16'h0001, '0, '0, DST_NOP, FN_ADD, SRC_AB, CIN_CSTORED, SHL_ZERO, STS_HOLD,
            IDBS_STS);
    add_row(16'h8000, 16'h0001, '0, '0, DST_NOP, FN_SUBS, SRC_AB, CIN_CINV, SHL_ZERO, STS_FLAGS,
            IDBS_F);
    for (int k = 0; k < 16; k++) begin             // Shift destination x link mode
      add_row(rand_word(), rand_word(), '0, '0, DST_QREG, FN_ADD, SRC_AB, CIN_ZERO, SHL_ZERO,
              STS_FLAGS, IDBS_F);
      add_row(rand_word(), rand_word(), '0, '0, 3'(4 + k / 4), FN_EXOR, SRC_AB, CIN_ZERO, 2'(k),
              STS_HOLD, IDBS_RB);
      add_row('0, '0, '0, '0, DST_NOP, FN_OR, SRC_ZQ, CIN_ZERO, SHL_ZERO, STS_HOLD, IDBS_Q);
    end
    add_row('0, '0, rand_word(), '0, DST_NOP, FN_AND, SRC_AB, CIN_ZERO, SHL_ZERO, STS_WORD, IDBS_CD);
    add_row('0, '0, rand_word(), '0, DST_NOP, FN_AND, SRC_AB, CIN_ZERO, SHL_ZERO, STS_PIL, IDBS_STS);
    add_row('0, '0, '0, '0, DST_NOP, FN_AND, SRC_AB, CIN_ZERO, SHL_ZERO, STS_HOLD, IDBS_STS);
    for (int k = 0; k < 8; k++) begin              // Every bus source
      add_row(rand_word(), rand_word(), rand_word(), rand_word(), DST_RAMU, FN_ADD, SRC_DA,
              CIN_ONE, SHL_ROT, STS_FLAGS, 3'(k));
    end
    for (int k = 0; k < 64; k++) begin
      add_row(rand_word(), rand_word(), rand_word(), rand_word(), 3'(rand_word()), 3'(rand_word()),
              3'(rand_word()), 2'(rand_word()), 2'(rand_word()), 2'(rand_word()), 3'(rand_word()));
    end
  endtask

  task automatic check_word(input string name, input int row,
                            input logic [`ALU_W-1:0] got, input logic [`ALU_W-1:0] exp);
    assert (got === exp) else begin
      $display("ERR %s row %0d: got %h expected %h", name, row, got, exp);
      $display("Checks failed");
      $fatal(1);
    end
  endtask

  // Combinational outputs plus state visible during the row
  task automatic check_live(input int i);
    check_word("rb", i, rb, tbl[i].exp_rb);
    check_word("f11", i, {15'h0, f11}, {15'h0, tbl[i].exp_f[11]});
    check_word("f15", i, {15'h0, f15}, {15'h0, tbl[i].exp_f[15]});
    check_word("cry", i, {15'h0, cry}, {15'h0, tbl[i].exp_flags[3]});
    check_word("ovf", i, {15'h0, ovf}, {15'h0, tbl[i].exp_flags[2]});
    check_word("zf", i, {15'h0, zf}, {15'h0, tbl[i].exp_flags[1]});
    check_word("mi", i, {15'h0, mi}, {15'h0, tbl[i].exp_flags[0]});
    check_word("sts", i, sts, tbl[i].exp_sts);
    check_word("pil", i, {12'h0, pil}, {12'h0, tbl[i].exp_sts[11:8]});
  endtask

  initial begin
    sysclk = 1'b0;
    forever #(CLK_NS / 2) sysclk = ~sysclk;
  end

  initial begin
    wait (built);
    #((n_rows + 20) * CLK_NS);
    $display("Timeout, run did not finish within %0d cycles", n_rows + 20);
    $display("Checks failed");
    $fatal(1);
  end

  initial begin
    arst_n = 1'b0;
    {a, b, cd, csbit, alu_i} = '0;
    cin_sel = CIN_ZERO;
    shl_sel = SHL_ZERO;
    sts_op = STS_HOLD;
    idbs = IDBS_F;
    build_table();
    built = 1'b1;
    repeat (5) @(posedge sysclk);
    @(negedge sysclk);
    arst_n = 1'b1;
    check_word("fidbo", -1, fidbo, '0);   // Cleared by reset
    check_word("sts", -1, sts, '0);
    check_word("pil", -1, {12'h0, pil}, '0);
    for (int i = 0; i < n_rows; i++) begin
      {a, b, cd, csbit, alu_i} = {tbl[i].a, tbl[i].b, tbl[i].cd, tbl[i].csbit, tbl[i].alu_i};
      cin_sel = cin_e'(tbl[i].cin_sel);
      shl_sel = shl_e'(tbl[i].shl_sel);
      sts_op = sts_op_e'(tbl[i].sts_op);
      idbs = idbs_e'(tbl[i].idbs);
      #1;
      check_live(i);
      @(negedge sysclk);
      check_word("fidbo", i, fidbo, tbl[i].exp_fidbo);   // Registered one edge later
    end
    $display("All checks passed");
    $finish;
  end

endmodule
